//--- common/core_pkg.sv
`default_nettype none

package core_pkg;

    // data and address width
    localparam int xlen = 64;

    // clint address window and its two registers
    localparam logic [xlen-1:0] clint_base         = 64'h0000_0000_0200_0000;
    localparam logic [xlen-1:0] clint_last         = 64'h0000_0000_0200_BFFF;
    localparam logic [xlen-1:0] clint_mtimecmp_adr = 64'h0000_0000_0200_4000;
    localparam logic [xlen-1:0] clint_mtime_adr    = 64'h0000_0000_0200_BFF8;

    // memory opcodes, the U variants zero extend
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_B    = 4'd1,
        MEM_H    = 4'd2,
        MEM_W    = 4'd3,
        MEM_D    = 4'd4,
        MEM_BU   = 4'd5,
        MEM_HU   = 4'd6,
        MEM_WU   = 4'd7
    } mem_op_e;

    // item handed over by execute
    typedef struct packed {
        mem_op_e          mem_op;
        logic             mem_wr;
        logic [xlen-1:0]  alu_res;
        logic [xlen-1:0]  rs2;
        logic [4:0]       rd;
        logic             reg_wr;
        logic [xlen-1:0]  pc;
    } lsu_req_t;

    // result for writeback
    typedef struct packed {
        logic [4:0]       rd;
        logic             reg_wr;
        logic [xlen-1:0]  wdata;
        logic [xlen-1:0]  pc;
    } wb_res_t;

    // bypass network
    typedef struct packed {
        logic             valid;
        logic [4:0]       rd;
        logic [xlen-1:0]  data;
    } fwd_t;

    // one ram access, size is log2 of the byte count
    typedef struct packed {
        logic [xlen-1:0]  adr;
        logic [xlen-1:0]  dat;
        logic [1:0]       size;
        logic             wr;
    } bus_req_t;

endpackage

`default_nettype wire

//--- lsu/load_align.sv
`default_nettype none

module load_align (
    input  wire logic [core_pkg::xlen-1:0] i_word,
    input  wire logic [2:0]                i_offset,
    input  wire core_pkg::mem_op_e         i_op,
    output logic [core_pkg::xlen-1:0]      o_data
);
    import core_pkg::*;

    logic [xlen-1:0] lane;

    // move the addressed byte to bit 0
    assign lane = i_word >> {i_offset, 3'b000};

    always_comb begin
        case (i_op)
            MEM_B: begin
                o_data = {{(xlen - 8){lane[7]}}, lane[7:0]};
            end
            MEM_H: begin
                o_data = {{(xlen - 16){lane[15]}}, lane[15:0]};
            end
            MEM_W: begin
                o_data = {{(xlen - 32){lane[31]}}, lane[31:0]};
            end
            MEM_BU: begin
                o_data = {{(xlen - 8){1'b0}}, lane[7:0]};
            end
            MEM_HU: begin
                o_data = {{(xlen - 16){1'b0}}, lane[15:0]};
            end
            MEM_WU: begin
                o_data = {{(xlen - 32){1'b0}}, lane[31:0]};
            end
            // doublewords and non-loads pass through
            default: begin
                o_data = i_word;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- lsu/wb_data_port.sv
`default_nettype none

module wb_data_port (
    input  wire logic                      clk,
    input  wire logic                      i_reset,
    input  wire logic                      i_start,
    input  wire core_pkg::bus_req_t        i_req,
    input  wire logic                      i_drop,
    output logic                           o_done,
    output logic [core_pkg::xlen-1:0]      o_rdata,
    output logic                           o_cyc,
    output logic                           o_stb,
    output logic                           o_we,
    output logic [core_pkg::xlen-1:0]      o_adr,
    output logic [core_pkg::xlen-1:0]      o_dat,
    output logic [core_pkg::xlen/8-1:0]    o_sel,
    input  wire logic [core_pkg::xlen-1:0] i_dat,
    input  wire logic                      i_ack
);
    import core_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        BUS,
        HOLD
    } port_state_e;

    port_state_e     state;
    logic            drop_pend;
    bus_req_t        req_q;
    bus_req_t        cur;
    logic [xlen-1:0] rdata_q;
    logic [2:0]      offset;
    logic            active;

    // first cycle drives straight from the request
    assign cur    = (state == IDLE) ? i_req : req_q;
    assign offset = cur.adr[2:0];
    assign active = (state == BUS) || ((state == IDLE) && i_start);

    assign o_cyc = active;
    assign o_stb = active;
    assign o_we  = cur.wr;
    assign o_adr = {cur.adr[xlen-1:3], 3'b000};
    assign o_dat = cur.dat << {offset, 3'b000};

    always_comb begin
        case (cur.size)
            2'd0:    o_sel = 8'h01 << offset;
            2'd1:    o_sel = 8'h03 << offset;
            2'd2:    o_sel = 8'h0f << offset;
            default: o_sel = 8'hff;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state     <= IDLE;
            drop_pend <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    drop_pend <= 1'b0;
                    if (i_start) begin
                        state <= BUS;
                    end
                end
                BUS: begin
                    // the cycle always completes, a drop only marks it
                    if (i_drop) begin
                        drop_pend <= 1'b1;
                    end
                    if (i_ack) begin
                        state <= HOLD;
                    end
                end
                default: begin
                    if (i_drop || drop_pend) begin
                        state     <= IDLE;
                        drop_pend <= 1'b0;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == IDLE) && i_start) begin
            req_q <= i_req;
        end
        if ((state == BUS) && i_ack) begin
            rdata_q <= i_dat;
        end
    end

    assign o_done  = (state == HOLD);
    assign o_rdata = rdata_q;

    // strobe and request lines hold still until the slave answers
    assert property (@(posedge clk) disable iff (i_reset)
        o_stb && !i_ack |=> o_stb && $stable(o_adr) && $stable(o_dat)
            && $stable(o_sel) && $stable(o_we));

endmodule

`default_nettype wire

//--- lsu/lsu.sv
`default_nettype none

module lsu (
    input  wire logic                      clk,
    input  wire logic                      i_reset,
    input  wire logic                      i_req_valid,
    input  wire core_pkg::lsu_req_t        i_req,
    output logic                           o_req_ready,
    output logic                           o_wb_valid,
    output core_pkg::wb_res_t              o_wb_res,
    input  wire logic                      i_wb_allowin,
    input  wire logic                      i_flush,
    output core_pkg::fwd_t                 o_fwd,
    output logic                           o_bus_start,
    output core_pkg::bus_req_t             o_bus_req,
    input  wire logic                      i_bus_done,
    input  wire logic [core_pkg::xlen-1:0] i_bus_rdata,
    output logic                           o_clint_we,
    output logic                           o_clint_re,
    output logic [core_pkg::xlen-1:0]      o_clint_adr,
    output logic [core_pkg::xlen-1:0]      o_clint_wdata,
    input  wire logic [core_pkg::xlen-1:0] i_clint_rdata
);
    import core_pkg::*;

    logic            mem_req;
    logic            rd_en;
    logic            wr_en;
    logic            is_clint;
    logic            is_ram;
    logic [1:0]      size;
    logic            bus_busy;
    logic            bus_stale;
    logic            ram_ready;
    logic            ready_go;
    logic            handoff;
    logic            release_item;
    logic [xlen-1:0] raw_word;
    logic [xlen-1:0] load_data;
    logic [xlen-1:0] wdata;

    // opcode decode
    assign mem_req = (i_req.mem_op != MEM_NONE);
    assign rd_en   = mem_req && !i_req.mem_wr;
    assign wr_en   = mem_req && i_req.mem_wr;

    always_comb begin
        case (i_req.mem_op)
            MEM_B, MEM_BU: size = 2'd0;
            MEM_H, MEM_HU: size = 2'd1;
            MEM_W, MEM_WU: size = 2'd2;
            default:       size = 2'd3;
        endcase
    end

    // address decode
    assign is_clint = (i_req.alu_res >= clint_base) && (i_req.alu_res <= clint_last);
    assign is_ram   = mem_req && !is_clint;

    // a stale request belongs to an item that was flushed while on the bus
    assign ram_ready = bus_busy && !bus_stale && i_bus_done;
    assign ready_go  = !is_ram || ram_ready;

    assign o_wb_valid   = i_req_valid && ready_go && !i_flush;
    assign o_req_ready  = !i_req_valid || i_flush || (ready_go && i_wb_allowin);
    assign handoff      = o_wb_valid && i_wb_allowin;
    assign release_item = i_req_valid && o_req_ready;

    // ram request, one per item
    assign o_bus_start   = i_req_valid && is_ram && !bus_busy && !i_flush;
    assign o_bus_req.adr  = i_req.alu_res;
    assign o_bus_req.dat  = i_req.rs2;
    assign o_bus_req.size = size;
    assign o_bus_req.wr   = wr_en;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            bus_busy  <= 1'b0;
            bus_stale <= 1'b0;
        end else if (o_bus_start) begin
            bus_busy <= 1'b1;
        end else if (bus_stale) begin
            // wait for the port to return the discarded result
            if (i_bus_done) begin
                bus_busy  <= 1'b0;
                bus_stale <= 1'b0;
            end
        end else if (bus_busy && release_item) begin
            if (i_bus_done) begin
                bus_busy <= 1'b0;
            end else begin
                bus_stale <= 1'b1;
            end
        end
    end

    // clint store lands only when the item leaves
    assign o_clint_we    = handoff && is_clint && wr_en;
    assign o_clint_re    = i_req_valid && is_clint && rd_en;
    assign o_clint_adr   = i_req.alu_res;
    assign o_clint_wdata = i_req.rs2;

    assign raw_word = is_clint ? i_clint_rdata : i_bus_rdata;

    load_align u_load_align (
        .i_word   (raw_word),
        .i_offset (i_req.alu_res[2:0]),
        .i_op     (i_req.mem_op),
        .o_data   (load_data)
    );

    assign wdata = rd_en ? load_data : i_req.alu_res;

    assign o_wb_res.rd     = i_req.rd;
    assign o_wb_res.reg_wr = i_req.reg_wr;
    assign o_wb_res.wdata  = wdata;
    assign o_wb_res.pc     = i_req.pc;

    assign o_fwd.valid = handoff && i_req.reg_wr;
    assign o_fwd.rd    = i_req.rd;
    assign o_fwd.data  = wdata;

    // the port must be free whenever a new request starts
    assert property (@(posedge clk) disable iff (i_reset)
        o_bus_start |-> !i_bus_done);

    // a ram result waiting on writeback stays in the port
    assert property (@(posedge clk) disable iff (i_reset)
        i_req_valid && ram_ready && !o_req_ready |=> i_bus_done && $stable(i_bus_rdata));

endmodule

`default_nettype wire

//--- src/clint.sv
`default_nettype none

module clint (
    input  wire logic                      clk,
    input  wire logic                      i_reset,
    input  wire logic                      i_we,
    input  wire logic                      i_re,
    input  wire logic [core_pkg::xlen-1:0] i_adr,
    input  wire logic [core_pkg::xlen-1:0] i_wdata,
    output logic [core_pkg::xlen-1:0]      o_rdata,
    output logic                           o_mtip
);
    import core_pkg::*;

    logic [xlen-1:0] mtime;
    logic [xlen-1:0] mtimecmp;
    logic [xlen-1:0] word_adr;
    logic            hit_mtime;
    logic            hit_mtimecmp;

    // registers are decoded on their doubleword
    assign word_adr     = {i_adr[xlen-1:3], 3'b000};
    assign hit_mtime    = (word_adr == clint_mtime_adr);
    assign hit_mtimecmp = (word_adr == clint_mtimecmp_adr);

    // free running timer
    always_ff @(posedge clk) begin
        if (i_reset) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 1'b1;
        end
    end

    // compare value starts out of reach
    always_ff @(posedge clk) begin
        if (i_reset) begin
            mtimecmp <= '1;
        end else if (i_we && hit_mtimecmp) begin
            mtimecmp <= i_wdata;
        end
    end

    always_comb begin
        o_rdata = '0;
        if (i_re) begin
            if (hit_mtime) begin
                o_rdata = mtime;
            end else if (hit_mtimecmp) begin
                o_rdata = mtimecmp;
            end
        end
    end

    assign o_mtip = (mtime >= mtimecmp);

endmodule

`default_nettype wire

//--- src/data_ram.sv
`default_nettype none

module data_ram #(
    parameter int ram_words = 512
) (
    input  wire logic                      clk,
    input  wire logic                      i_reset,
    input  wire logic                      i_cyc,
    input  wire logic                      i_stb,
    input  wire logic                      i_we,
    input  wire logic [core_pkg::xlen-1:0] i_adr,
    input  wire logic [core_pkg::xlen-1:0] i_dat,
    input  wire logic [core_pkg::xlen/8-1:0] i_sel,
    output logic [core_pkg::xlen-1:0]      o_dat,
    output logic                           o_ack
);
    import core_pkg::*;

    localparam int idx_bits = $clog2(ram_words);

    logic [xlen-1:0]     mem [ram_words];
    logic [idx_bits-1:0] idx;
    logic                access;

    // word index, upper address bits wrap
    assign idx    = i_adr[idx_bits+2:3];
    assign access = i_cyc && i_stb && !o_ack;

    always_ff @(posedge clk) begin
        if (access) begin
            if (i_we) begin
                for (int b = 0; b < xlen / 8; b++) begin
                    if (i_sel[b]) begin
                        mem[idx][8*b +: 8] <= i_dat[8*b +: 8];
                    end
                end
            end
            o_dat <= mem[idx];
        end
    end

    // one ack per strobe
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= access;
        end
    end

    // ack answers a strobe that the master still holds
    assert property (@(posedge clk) disable iff (i_reset)
        o_ack |-> i_cyc && i_stb);

endmodule

`default_nettype wire

//--- src/mem_stage_top.sv
`default_nettype none

module mem_stage_top #(
    parameter int ram_words = 512
) (
    input  wire logic               clk,
    input  wire logic               i_reset,
    input  wire logic               i_req_valid,
    input  wire core_pkg::lsu_req_t i_req,
    output logic                    o_req_ready,
    output logic                    o_wb_valid,
    output core_pkg::wb_res_t       o_wb_res,
    input  wire logic               i_wb_allowin,
    input  wire logic               i_flush,
    input  wire logic               i_mie,
    output core_pkg::fwd_t          o_fwd,
    output logic                    o_timer_irq
);
    import core_pkg::*;

    logic              bus_start;
    bus_req_t          bus_req;
    logic              bus_done;
    logic [xlen-1:0]   bus_rdata;
    logic              clint_we;
    logic              clint_re;
    logic [xlen-1:0]   clint_adr;
    logic [xlen-1:0]   clint_wdata;
    logic [xlen-1:0]   clint_rdata;
    logic              mtip;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [xlen-1:0]   wb_adr;
    logic [xlen-1:0]   wb_dat_w;
    logic [xlen/8-1:0] wb_sel;
    logic [xlen-1:0]   wb_dat_r;
    logic              wb_ack;

    lsu u_lsu (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_req_valid   (i_req_valid),
        .i_req         (i_req),
        .o_req_ready   (o_req_ready),
        .o_wb_valid    (o_wb_valid),
        .o_wb_res      (o_wb_res),
        .i_wb_allowin  (i_wb_allowin),
        .i_flush       (i_flush),
        .o_fwd         (o_fwd),
        .o_bus_start   (bus_start),
        .o_bus_req     (bus_req),
        .i_bus_done    (bus_done),
        .i_bus_rdata   (bus_rdata),
        .o_clint_we    (clint_we),
        .o_clint_re    (clint_re),
        .o_clint_adr   (clint_adr),
        .o_clint_wdata (clint_wdata),
        .i_clint_rdata (clint_rdata)
    );

    // the port lets go of its result whenever the stage releases its item
    wb_data_port u_wb_data_port (
        .clk     (clk),
        .i_reset (i_reset),
        .i_start (bus_start),
        .i_req   (bus_req),
        .i_drop  (o_req_ready),
        .o_done  (bus_done),
        .o_rdata (bus_rdata),
        .o_cyc   (wb_cyc),
        .o_stb   (wb_stb),
        .o_we    (wb_we),
        .o_adr   (wb_adr),
        .o_dat   (wb_dat_w),
        .o_sel   (wb_sel),
        .i_dat   (wb_dat_r),
        .i_ack   (wb_ack)
    );

    clint u_clint (
        .clk     (clk),
        .i_reset (i_reset),
        .i_we    (clint_we),
        .i_re    (clint_re),
        .i_adr   (clint_adr),
        .i_wdata (clint_wdata),
        .o_rdata (clint_rdata),
        .o_mtip  (mtip)
    );

    data_ram #(
        .ram_words (ram_words)
    ) u_data_ram (
        .clk     (clk),
        .i_reset (i_reset),
        .i_cyc   (wb_cyc),
        .i_stb   (wb_stb),
        .i_we    (wb_we),
        .i_adr   (wb_adr),
        .i_dat   (wb_dat_w),
        .i_sel   (wb_sel),
        .o_dat   (wb_dat_r),
        .o_ack   (wb_ack)
    );

    // timer interrupt gated by mie
    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_timer_irq <= 1'b0;
        end else begin
            o_timer_irq <= i_mie && mtip;
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_mem_stage.sv
`default_nettype none

module tb_mem_stage;
    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;

    localparam int              ram_words = 512;
    localparam logic [xlen-1:0] ram_base  = 64'h0000_0000_8000_0100;
    localparam logic [xlen-1:0] cmp_value = 64'h1234_5678_9abc_def0;
    localparam logic [1:0]      chk_exact = 2'd0;
    localparam logic [1:0]      chk_model = 2'd1;
    localparam logic [1:0]      chk_time  = 2'd2;
    localparam int              max_wait  = 40;

    // one row: stimulus, flags and the expected writeback data
    typedef struct packed {
        mem_op_e         op;
        logic            wr;
        logic [xlen-1:0] adr;
        logic [xlen-1:0] dat;
        logic [4:0]      rd;
        logic            reg_wr;
        logic            flush;
        logic            stall;
        logic [1:0]      chk;
        logic [xlen-1:0] exp;
    } step_t;

    logic            clk;
    logic            i_reset;
    logic            i_req_valid;
    lsu_req_t        i_req;
    logic            o_req_ready;
    logic            o_wb_valid;
    wb_res_t         o_wb_res;
    logic            i_wb_allowin;
    logic            i_flush;
    logic            i_mie;
    fwd_t            o_fwd;
    logic            o_timer_irq;

    step_t           steps[$];
    logic [7:0]      ref_mem [ram_words * 8];
    logic [15:0]     lfsr = 16'd40130;
    logic [xlen-1:0] prev_mtime;
    logic [xlen-1:0] next_pc;

    mem_stage_top #(
        .ram_words (ram_words)
    ) dut (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_req_valid  (i_req_valid),
        .i_req        (i_req),
        .o_req_ready  (o_req_ready),
        .o_wb_valid   (o_wb_valid),
        .o_wb_res     (o_wb_res),
        .i_wb_allowin (i_wb_allowin),
        .i_flush      (i_flush),
        .i_mie        (i_mie),
        .o_fwd        (o_fwd),
        .o_timer_irq  (o_timer_irq)
    );

    always #50 clk = ~clk;

    task automatic expect_equal(input logic [xlen-1:0] actual, input logic [xlen-1:0] expected,
            input string what);
        if (actual !== expected) begin
            $display("error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout at %0t ns: %s did not happen within %0d cycles", $time, what, max_wait);
        $display("RESULT: FAIL");
        $fatal(1, "stopping on timeout");
    endtask

    // 16 bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [xlen-1:0] random_bits(input int n);
        logic [xlen-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[xlen-2:0], next_random_bit()};
        end
        return v;
    endfunction

    function automatic int op_bytes(input mem_op_e op);
        case (op)
            MEM_B, MEM_BU: return 1;
            MEM_H, MEM_HU: return 2;
            MEM_W, MEM_WU: return 4;
            default:       return 8;
        endcase
    endfunction

    function automatic logic in_clint(input logic [xlen-1:0] adr);
        return (adr >= clint_base) && (adr <= clint_last);
    endfunction

    // little endian assembly from the byte model, ram holds 4 KiB
    function automatic logic [xlen-1:0] model_load(input mem_op_e op, input logic [xlen-1:0] adr);
        logic [xlen-1:0] v;
        int              n;
        int              base;
        n = op_bytes(op);
        base = int'(adr[11:0]);
        v = '0;
        for (int i = n - 1; i >= 0; i--) begin
            v = {v[xlen-9:0], ref_mem[base + i]};
        end
        if ((op == MEM_B || op == MEM_H || op == MEM_W) && v[8 * n - 1]) begin
            v = v | ({xlen{1'b1}} << (8 * n));
        end
        return v;
    endfunction

    function automatic void model_store(input mem_op_e op, input logic [xlen-1:0] adr,
            input logic [xlen-1:0] dat);
        int base;
        base = int'(adr[11:0]);
        for (int i = 0; i < op_bytes(op); i++) begin
            ref_mem[base + i] = dat[8 * i +: 8];
        end
    endfunction

    task automatic add_step(input mem_op_e op, input logic wr, input logic [xlen-1:0] adr,
            input logic [xlen-1:0] dat, input logic [4:0] rd, input logic reg_wr,
            input logic flush, input logic stall, input logic [1:0] chk,
            input logic [xlen-1:0] exp);
        step_t s;
        s.op = op;
        s.wr = wr;
        s.adr = adr;
        s.dat = dat;
        s.rd = rd;
        s.reg_wr = reg_wr;
        s.flush = flush;
        s.stall = stall;
        s.chk = chk;
        s.exp = exp;
        steps.push_back(s);
    endtask

    task automatic apply_step(input step_t s);
        lsu_req_t        req;
        logic [xlen-1:0] exp_data;
        wb_res_t         held_res;
        logic            held;
        logic            finished;
        logic            leaving;
        int              handoffs;
        int              cycles;
        req.mem_op = s.op;
        req.mem_wr = s.wr;
        req.alu_res = s.adr;
        req.rs2 = s.dat;
        req.rd = s.rd;
        req.reg_wr = s.reg_wr;
        req.pc = next_pc;
        next_pc = next_pc + 64'd4;
        exp_data = s.exp;
        if (s.chk == chk_model && s.op != MEM_NONE && !s.wr) begin
            exp_data = model_load(s.op, s.adr);
        end
        held = 1'b0;
        finished = 1'b0;
        handoffs = 0;
        cycles = 0;
        @(posedge clk);
        #1;
        i_req_valid = 1'b1;
        i_req = req;
        i_flush = s.flush;
        i_wb_allowin = s.stall ? next_random_bit() : 1'b1;
        while (!finished) begin
            @(negedge clk);
            leaving = o_wb_valid && i_wb_allowin;
            if (s.flush) begin
                expect_equal(64'(o_wb_valid), 64'd0, "flushed item reached writeback");
            end
            if (held) begin
                expect_equal(64'(o_wb_valid), 64'd1, "result withdrawn before hand-off");
                expect_equal(o_wb_res.wdata, held_res.wdata, "wdata changed while stalled");
                expect_equal(o_wb_res.pc, held_res.pc, "pc changed while stalled");
            end
            expect_equal(64'(o_fwd.valid), 64'(leaving && s.reg_wr), "forward valid");
            if (leaving) begin
                handoffs++;
                expect_equal(64'(o_wb_res.rd), 64'(s.rd), "writeback rd");
                expect_equal(64'(o_wb_res.reg_wr), 64'(s.reg_wr), "writeback reg_wr");
                expect_equal(o_wb_res.pc, req.pc, "writeback pc, item order");
                if (s.chk == chk_time) begin
                    // the counter moves every clock, so a later read is larger
                    expect_equal(64'(o_wb_res.wdata > prev_mtime), 64'd1,
                                 "mtime did not advance");
                    prev_mtime = o_wb_res.wdata;
                end else begin
                    expect_equal(o_wb_res.wdata, exp_data, "writeback data");
                end
                if (s.reg_wr) begin
                    expect_equal(64'(o_fwd.rd), 64'(s.rd), "forward rd");
                    if (s.chk == chk_time) begin
                        expect_equal(o_fwd.data, prev_mtime, "forward mtime");
                    end else begin
                        expect_equal(o_fwd.data, exp_data, "forward data");
                    end
                end
            end else if (o_wb_valid) begin
                held = 1'b1;
                held_res = o_wb_res;
            end
            if (o_req_ready) begin
                finished = 1'b1;
            end else begin
                cycles++;
                if (cycles > max_wait) begin
                    fail_timeout("stage ready");
                end
                @(posedge clk);
                #1;
                i_wb_allowin = s.stall ? next_random_bit() : 1'b1;
            end
        end
        expect_equal(64'(handoffs), s.flush ? 64'd0 : 64'd1, "hand-off count");
        if (s.wr && s.op != MEM_NONE && !s.flush && !in_clint(s.adr)) begin
            model_store(s.op, s.adr, s.dat);
        end
    endtask

    task automatic run_steps();
        foreach (steps[i]) begin
            apply_step(steps[i]);
        end
        steps.delete();
        @(posedge clk);
        #1;
        i_req_valid = 1'b0;
        i_flush = 1'b0;
        i_wb_allowin = 1'b1;
    endtask

    task automatic build_steps();
        mem_op_e         store_ops [4];
        mem_op_e         load_ops [7];
        logic [xlen-1:0] adr;
        int              sz;
        store_ops = '{MEM_B, MEM_H, MEM_W, MEM_D};
        load_ops = '{MEM_B, MEM_H, MEM_W, MEM_D, MEM_BU, MEM_HU, MEM_WU};
        for (int i = 0; i < 4; i++) begin
            adr = random_bits(64);
            add_step(MEM_NONE, 1'b0, adr, random_bits(64), 5'(random_bits(5)), i[0], 1'b0,
                     1'b1, chk_exact, adr);
        end
        add_step(MEM_NONE, 1'b0, 64'h55, 64'd0, 5'd3, 1'b1, 1'b1, 1'b1, chk_exact, 64'd0);
        // fill four words, then overwrite one word per size at every offset
        for (int w = 0; w < 4; w++) begin
            adr = ram_base + 64'(8 * w);
            add_step(MEM_D, 1'b1, adr, random_bits(64), 5'd0, 1'b0, 1'b0, 1'b1, chk_model, adr);
        end
        for (int w = 0; w < 4; w++) begin
            sz = 1 << w;
            for (int off = 0; off < 8; off += sz) begin
                adr = ram_base + 64'(8 * w + off);
                add_step(store_ops[w], 1'b1, adr, random_bits(64), 5'd0, 1'b0, 1'b0, 1'b1,
                         chk_model, adr);
            end
        end
        add_step(MEM_D, 1'b1, ram_base, 64'hdead_beef_0bad_f00d, 5'd0, 1'b0, 1'b1, 1'b1,
                 chk_model, ram_base);
        add_step(MEM_D, 1'b0, ram_base, 64'd0, 5'd7, 1'b1, 1'b1, 1'b1, chk_model, 64'd0);
        for (int w = 0; w < 4; w++) begin
            for (int k = 0; k < 7; k++) begin
                sz = op_bytes(load_ops[k]);
                for (int off = 0; off < 8; off += sz) begin
                    adr = ram_base + 64'(8 * w + off);
                    add_step(load_ops[k], 1'b0, adr, 64'd0, 5'(random_bits(5)), 1'b1, 1'b0,
                             1'b1, chk_model, 64'd0);
                end
            end
        end
        // timer registers, no stalls so mtime reads stay exact
        add_step(MEM_D, 1'b1, clint_mtimecmp_adr, cmp_value, 5'd0, 1'b0, 1'b0, 1'b0,
                 chk_exact, clint_mtimecmp_adr);
        add_step(MEM_D, 1'b0, clint_mtimecmp_adr, 64'd0, 5'd9, 1'b1, 1'b0, 1'b0,
                 chk_exact, cmp_value);
        add_step(MEM_D, 1'b0, clint_mtime_adr, 64'd0, 5'd10, 1'b1, 1'b0, 1'b0, chk_time, 64'd0);
        add_step(MEM_D, 1'b0, clint_mtime_adr, 64'd0, 5'd11, 1'b1, 1'b0, 1'b0, chk_time, 64'd0);
        add_step(MEM_D, 1'b1, clint_mtimecmp_adr, 64'd0, 5'd0, 1'b0, 1'b1, 1'b0,
                 chk_exact, 64'd0);
        add_step(MEM_D, 1'b0, clint_mtimecmp_adr, 64'd0, 5'd12, 1'b1, 1'b0, 1'b0,
                 chk_exact, cmp_value);
        add_step(MEM_WU, 1'b0, clint_mtimecmp_adr + 64'd4, 64'd0, 5'd13, 1'b1, 1'b0, 1'b0,
                 chk_exact, 64'h0000_0000_1234_5678);
    endtask

    task automatic wait_for_irq();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!o_timer_irq) begin
            cycles++;
            if (cycles > max_wait) begin
                fail_timeout("timer interrupt");
            end
            @(negedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        i_reset = 1'b1;
        i_req_valid = 1'b0;
        i_req = '0;
        i_wb_allowin = 1'b1;
        i_flush = 1'b0;
        i_mie = 1'b1;
        prev_mtime = '0;
        next_pc = 64'h0000_0000_1000_0000;
        repeat (2) @(posedge clk);
        #1;
        i_reset = 1'b0;
        @(negedge clk);
        expect_equal(64'(o_wb_valid), 64'd0, "wb valid after reset");
        expect_equal(64'(o_fwd.valid), 64'd0, "forward valid after reset");
        expect_equal(64'(o_timer_irq), 64'd0, "timer irq after reset");
        build_steps();
        run_steps();
        @(negedge clk);
        expect_equal(64'(o_timer_irq), 64'd0, "timer irq with mtimecmp ahead");
        // compare value below mtime, first masked
        @(posedge clk);
        #1;
        i_mie = 1'b0;
        add_step(MEM_D, 1'b1, clint_mtimecmp_adr, 64'd0, 5'd0, 1'b0, 1'b0, 1'b0,
                 chk_exact, clint_mtimecmp_adr);
        add_step(MEM_D, 1'b0, clint_mtimecmp_adr, 64'd0, 5'd14, 1'b1, 1'b0, 1'b0,
                 chk_exact, 64'd0);
        run_steps();
        repeat (4) begin
            @(negedge clk);
            expect_equal(64'(o_timer_irq), 64'd0, "timer irq while masked");
        end
        @(posedge clk);
        #1;
        i_mie = 1'b1;
        wait_for_irq();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
common/core_pkg.sv
lsu/load_align.sv
lsu/wb_data_port.sv
lsu/lsu.sv
src/clint.sv
src/data_ram.sv
src/mem_stage_top.sv
tests/tb_mem_stage.sv

//--- Makefile
# Verilator build and run of the memory stage testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --top-module tb_mem_stage -f files.f
	-./obj_dir/Vtb_mem_stage | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" sim.log || (echo "no result in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
